// ==== common/seqPkg.sv ====
package seqPkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int pcWidth    = 14;  // Program address
  localparam int countWidth = 7;   // Loop count
  localparam int cmdWidth   = 24;  // Sequencer command word

  //////////////////////////////////////////////////
  // Opcodes in the top three bits of a command
  //////////////////////////////////////////////////

  localparam logic [2:0] opNop  = 3'd0;  // Sequential advance
  localparam logic [2:0] opJump = 3'd1;
  localparam logic [2:0] opCall = 3'd2;
  localparam logic [2:0] opRet  = 3'd3;
  localparam logic [2:0] opDo   = 3'd4;  // Loop start

  // The opcode field is common to both views and selects which one applies
  typedef union packed {
    struct packed {
      logic [2:0]         opcode;
      logic [6:0]         unused;
      logic [pcWidth-1:0] target;
    } branch;
    struct packed {
      logic [2:0]            opcode;
      logic [countWidth-1:0] count;
      logic [pcWidth-1:0]    endAddr;
    } loop;
  } seqCmd_u;

endpackage

// ==== pcStack/pcStack.sv ====
`timescale 1ns/1ps

module pcStack #(
  parameter int pcStackDepth = 16
) (
  input  logic                       PCSCLK,
  input  logic                       T_RST,
  input  logic                       pcPush,
  input  logic                       pcPop,
  input  logic [seqPkg::pcWidth-1:0] pcIn,
  output logic [seqPkg::pcWidth-1:0] topPc,
  output logic                       pcFull,
  output logic                       pcEmpty,
  output logic                       pcError
);
  import seqPkg::*;

  localparam int addrWidth = (pcStackDepth > 1) ? $clog2(pcStackDepth) : 1;
  localparam int ptrWidth  = addrWidth + 1;

  logic [pcWidth-1:0]  stackMem [pcStackDepth];
  logic [ptrWidth-1:0] ptr;
  logic [ptrWidth-1:0] ptrInc;
  logic [ptrWidth-1:0] ptrDec;
  logic                doPush;
  logic                doPop;

  //////////////////////////////////////////////////
  // Pointer and flags
  //////////////////////////////////////////////////

  // All ones after reset, so the top bit doubles as the empty flag
  assign ptrInc  = ptr + 1'b1;
  assign ptrDec  = ptr - 1'b1;
  assign pcEmpty = ptr[ptrWidth-1];
  assign pcFull  = (ptr == ptrWidth'(pcStackDepth - 1));

  // Overflow and underflow requests are dropped here
  assign doPush = pcPush && !pcFull;
  assign doPop  = pcPop && !pcEmpty;

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1;
    end else if (doPush) begin
      ptr <= ptrInc;
    end else if (doPop) begin
      ptr <= ptrDec;
    end
  end

  // Sticky until reset
  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      pcError <= 1'b0;
    end else if ((pcPush && pcFull) || (pcPop && pcEmpty)) begin
      pcError <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////

  always_ff @(posedge PCSCLK) begin
    if (doPush) begin
      stackMem[ptrInc[addrWidth-1:0]] <= pcIn;  // Next free slot
    end
  end

  // Top of stack is read without a clock
  assign topPc = stackMem[ptr[addrWidth-1:0]];

endmodule

// ==== rtl/loopStack.sv ====
`timescale 1ns/1ps

module loopStack #(
  parameter int loopStackDepth = 4
) (
  input  logic                          PCSCLK,
  input  logic                          T_RST,
  input  logic                          loopPush,
  input  logic                          loopPop,
  input  logic                          loopDec,
  input  logic [seqPkg::pcWidth-1:0]    endIn,
  input  logic [seqPkg::countWidth-1:0] countIn,
  output logic [seqPkg::pcWidth-1:0]    topEnd,
  output logic [seqPkg::countWidth-1:0] topCount,
  output logic                          loopEmpty,
  output logic                          loopError
);
  import seqPkg::*;

  localparam int addrWidth = (loopStackDepth > 1) ? $clog2(loopStackDepth) : 1;
  localparam int ptrWidth  = addrWidth + 1;

  logic [pcWidth-1:0]    endMem   [loopStackDepth];
  logic [countWidth-1:0] countMem [loopStackDepth];
  logic [ptrWidth-1:0]   ptr;
  logic [ptrWidth-1:0]   ptrInc;
  logic [addrWidth-1:0]  topIdx;
  logic                  loopFull;
  logic                  doPush;
  logic                  doPop;
  logic                  doDec;

  assign ptrInc    = ptr + 1'b1;
  assign topIdx    = ptr[addrWidth-1:0];
  assign loopEmpty = ptr[ptrWidth-1];
  assign loopFull  = (ptr == ptrWidth'(loopStackDepth - 1));

  assign doPush = loopPush && !loopFull;
  assign doPop  = loopPop && !loopEmpty;
  assign doDec  = loopDec && !loopEmpty;

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1;
    end else if (doPush) begin
      ptr <= ptrInc;
    end else if (doPop) begin
      ptr <= ptr - 1'b1;
    end
  end

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      loopError <= 1'b0;
    end else if ((loopPush && loopFull) || (loopPop && loopEmpty)) begin
      loopError <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // End address and count pairs
  //////////////////////////////////////////////////

  always_ff @(posedge PCSCLK) begin
    if (doPush) begin
      endMem[ptrInc[addrWidth-1:0]]   <= endIn;
      countMem[ptrInc[addrWidth-1:0]] <= countIn;
    end else if (doDec) begin
      // One pass of the innermost loop is done
      countMem[topIdx] <= topCount - 1'b1;
    end
  end

  assign topEnd   = endMem[topIdx];
  assign topCount = countMem[topIdx];

endmodule

// ==== rtl/pcSequencer.sv ====
`timescale 1ns/1ps

module pcSequencer #(
  parameter logic [seqPkg::pcWidth-1:0] resetVector = '0
) (
  input  logic                          PCSCLK,
  input  logic                          T_RST,
  input  logic                          cmdValid,
  input  seqPkg::seqCmd_u               cmdWord,
  output logic                          cmdReady,
  output logic                          fetchValid,
  output logic [seqPkg::pcWidth-1:0]    fetchAddr,
  input  logic                          fetchReady,
  output logic                          pcPush,
  output logic                          pcPop,
  output logic [seqPkg::pcWidth-1:0]    pcIn,
  input  logic [seqPkg::pcWidth-1:0]    topPc,
  output logic                          loopPush,
  output logic                          loopPop,
  output logic                          loopDec,
  output logic [seqPkg::pcWidth-1:0]    endIn,
  output logic [seqPkg::countWidth-1:0] countIn,
  input  logic [seqPkg::pcWidth-1:0]    topEnd,
  input  logic [seqPkg::countWidth-1:0] topCount,
  input  logic                          loopEmpty
);
  import seqPkg::*;

  logic [pcWidth-1:0] pcReg;
  logic [pcWidth-1:0] pcPlusOne;
  logic [pcWidth-1:0] nextPc;
  logic               cmdAccept;
  logic               loopHit;
  logic               loopAgain;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // A held fetch address blocks new commands until it is taken
  assign cmdReady  = !fetchValid || fetchReady;
  assign cmdAccept = cmdValid && cmdReady;

  //////////////////////////////////////////////////
  // Next-address decode
  //////////////////////////////////////////////////

  assign pcPlusOne = pcReg + 1'b1;
  assign loopHit   = !loopEmpty && (pcReg == topEnd);
  assign loopAgain = (topCount > countWidth'(1));  // A count of zero ends like one

  // Return address for both calls and loop starts
  assign pcIn    = pcPlusOne;
  assign endIn   = cmdWord.loop.endAddr;
  assign countIn = cmdWord.loop.count;

  always_comb begin
    nextPc   = pcPlusOne;
    pcPush   = 1'b0;
    pcPop    = 1'b0;
    loopPush = 1'b0;
    loopPop  = 1'b0;
    loopDec  = 1'b0;
    case (cmdWord.branch.opcode)
      opJump: begin
        nextPc = cmdWord.branch.target;
      end
      opCall: begin
        nextPc = cmdWord.branch.target;
        pcPush = cmdAccept;
      end
      opRet: begin
        nextPc = topPc;  // Stale on an empty stack
        pcPop  = cmdAccept;
      end
      opDo: begin
        pcPush   = cmdAccept;
        loopPush = cmdAccept;
      end
      default: begin
        if (loopHit && loopAgain) begin
          nextPc  = topPc;  // Back to the loop start
          loopDec = cmdAccept;
        end else if (loopHit) begin
          pcPop   = cmdAccept;
          loopPop = cmdAccept;
        end
      end
    endcase
  end

  //////////////////////////////////////////////////
  // PC register and fetch valid
  //////////////////////////////////////////////////

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      pcReg      <= resetVector;
      fetchValid <= 1'b0;
    end else if (cmdAccept) begin
      pcReg      <= nextPc;
      fetchValid <= 1'b1;
    end else if (fetchReady) begin
      fetchValid <= 1'b0;
    end
  end

  assign fetchAddr = pcReg;

endmodule

// ==== rtl/seqTop.sv ====
`timescale 1ns/1ps

module seqTop #(
  parameter int                         pcStackDepth   = 16,
  parameter int                         loopStackDepth = 4,
  parameter logic [seqPkg::pcWidth-1:0] resetVector    = '0
) (
  input  logic                        PCSCLK,
  input  logic                        T_RST,
  input  logic                        cmdValid,
  input  logic [seqPkg::cmdWidth-1:0] cmdWord,
  output logic                        cmdReady,
  output logic                        fetchValid,
  output logic [seqPkg::pcWidth-1:0]  fetchAddr,
  input  logic                        fetchReady,
  output logic                        pcFull,
  output logic                        pcEmpty,
  output logic                        pcError,
  output logic                        loopError
);
  import seqPkg::*;

  logic                  pcPush;
  logic                  pcPop;
  logic [pcWidth-1:0]    pcIn;
  logic [pcWidth-1:0]    topPc;
  logic                  loopPush;
  logic                  loopPop;
  logic                  loopDec;
  logic [pcWidth-1:0]    endIn;
  logic [countWidth-1:0] countIn;
  logic [pcWidth-1:0]    topEnd;
  logic [countWidth-1:0] topCount;
  logic                  loopEmpty;

  pcSequencer #(
    .resetVector(resetVector)
  ) sequencer (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmdWord   (cmdWord),
    .cmdReady  (cmdReady),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr),
    .fetchReady(fetchReady),
    .pcPush    (pcPush),
    .pcPop     (pcPop),
    .pcIn      (pcIn),
    .topPc     (topPc),
    .loopPush  (loopPush),
    .loopPop   (loopPop),
    .loopDec   (loopDec),
    .endIn     (endIn),
    .countIn   (countIn),
    .topEnd    (topEnd),
    .topCount  (topCount),
    .loopEmpty (loopEmpty)
  );

  pcStack #(
    .pcStackDepth(pcStackDepth)
  ) returnStack (
    .PCSCLK (PCSCLK),
    .T_RST  (T_RST),
    .pcPush (pcPush),
    .pcPop  (pcPop),
    .pcIn   (pcIn),
    .topPc  (topPc),
    .pcFull (pcFull),
    .pcEmpty(pcEmpty),
    .pcError(pcError)
  );

  loopStack #(
    .loopStackDepth(loopStackDepth)
  ) doStack (
    .PCSCLK   (PCSCLK),
    .T_RST    (T_RST),
    .loopPush (loopPush),
    .loopPop  (loopPop),
    .loopDec  (loopDec),
    .endIn    (endIn),
    .countIn  (countIn),
    .topEnd   (topEnd),
    .topCount (topCount),
    .loopEmpty(loopEmpty),
    .loopError(loopError)
  );

endmodule

// ==== bench/seqTop_assert.sv ====
`timescale 1ns/1ps

module seqTopAssert (
  input logic                       PCSCLK,
  input logic                       T_RST,
  input logic                       cmdReady,
  input logic                       fetchValid,
  input logic                       fetchReady,
  input logic [seqPkg::pcWidth-1:0] fetchAddr,
  input logic                       pcPush,
  input logic                       pcPop,
  input logic                       loopPush,
  input logic                       loopPop
);

  //////////////////////////////////////////////////
  // Stack strobes
  //////////////////////////////////////////////////

  pcPushPop: assert property (@(posedge PCSCLK) disable iff (T_RST) !(pcPush && pcPop))
    else $error("PC stack push and pop in the same cycle");

  loopPushPop: assert property (@(posedge PCSCLK) disable iff (T_RST) !(loopPush && loopPop))
    else $error("Loop stack push and pop in the same cycle");

  //////////////////////////////////////////////////
  // Fetch stall
  //////////////////////////////////////////////////

  // A stalled fetch holds its address into the next cycle
  fetchHold: assert property (@(posedge PCSCLK) disable iff (T_RST)
    fetchValid && !fetchReady |=> fetchValid && (fetchAddr === $past(fetchAddr)))
    else $error("Fetch address changed while stalled");

  stallBlocksCmd: assert property (@(posedge PCSCLK) disable iff (T_RST)
    fetchValid && !fetchReady |-> !cmdReady)
    else $error("Command port ready while the fetch port is stalled");

endmodule

// ==== bench/seqTb.sv ====
`timescale 1ns/1ps

module seqTb;
  import seqPkg::*;

  localparam int resetAddr = 0;

  logic                PCSCLK;
  logic                T_RST;
  logic                cmdValid;
  logic [cmdWidth-1:0] cmdWord;
  logic                cmdReady;
  logic                fetchValid;
  logic [pcWidth-1:0]  fetchAddr;
  logic                fetchReady;
  logic                pcFull;
  logic                pcEmpty;
  logic                pcError;
  logic                loopError;

  // One entry per command, with the fetch and flags it should produce
  seqCmd_u            cmdTab[$];
  logic [pcWidth-1:0] addrTab[$];
  logic               addrKnownTab[$];
  logic               pcErrTab[$];
  logic               loopErrTab[$];
  logic               emptyTab[$];
  logic               fullTab[$];

  int cycleCount;
  int cycleLimit;

  // A small PC stack, so that the last run of loop starts fills it
  seqTop #(
    .pcStackDepth  (4),
    .loopStackDepth(4),
    .resetVector   (pcWidth'(resetAddr))
  ) uut (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmdWord   (cmdWord),
    .cmdReady  (cmdReady),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr),
    .fetchReady(fetchReady),
    .pcFull    (pcFull),
    .pcEmpty   (pcEmpty),
    .pcError   (pcError),
    .loopError (loopError)
  );

  bind seqTop seqTopAssert checks (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .cmdReady  (cmdReady),
    .fetchValid(fetchValid),
    .fetchReady(fetchReady),
    .fetchAddr (fetchAddr),
    .pcPush    (pcPush),
    .pcPop     (pcPop),
    .loopPush  (loopPush),
    .loopPop   (loopPop)
  );

  always #50 PCSCLK = ~PCSCLK;

  // The fetch side stalls about one cycle in four
  always @(posedge PCSCLK) begin
    #1;
    fetchReady = ($urandom % 4) != 0;
  end

  always @(posedge PCSCLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      abortRun($sformatf("Timeout: the run did not finish within %0d clock cycles", cycleLimit));
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkAddr(input string name, input logic [pcWidth-1:0] got,
                           input logic [pcWidth-1:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("[FAIL] time %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abortRun($sformatf("[FAIL] time %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  function automatic seqCmd_u branchCmd(input logic [2:0] op, input int target);
    seqCmd_u cmd;
    cmd               = '0;
    cmd.branch.opcode = op;
    cmd.branch.target = pcWidth'(target);
    return cmd;
  endfunction

  function automatic seqCmd_u loopCmd(input int count, input int endAddr);
    seqCmd_u cmd;
    cmd              = '0;
    cmd.loop.opcode  = opDo;
    cmd.loop.count   = countWidth'(count);
    cmd.loop.endAddr = pcWidth'(endAddr);
    return cmd;
  endfunction

  task automatic addRow(input seqCmd_u cmd, input int addr, input int known,
                        input int pcErr, input int loopErr, input int empty,
                        input int full = 0);
    cmdTab.push_back(cmd);
    addrTab.push_back(pcWidth'(addr));
    addrKnownTab.push_back(known != 0);
    pcErrTab.push_back(pcErr != 0);
    loopErrTab.push_back(loopErr != 0);
    emptyTab.push_back(empty != 0);
    fullTab.push_back(full != 0);
  endtask

  // Columns are command, fetch address, address checked, pcError, loopError, pcEmpty, pcFull
  task automatic buildTable();
    seqCmd_u adv;
    seqCmd_u ret;
    adv = branchCmd(opNop, 0);
    ret = branchCmd(opRet, 0);
    for (int k = 1; k <= 5; k++) begin
      addRow(adv, resetAddr + k, 1, 0, 0, 1);
    end
    addRow(branchCmd(opJump, 100), 100, 1, 0, 0, 1);
    addRow(branchCmd(opCall, 200), 200, 1, 0, 0, 0);
    addRow(adv, 201, 1, 0, 0, 0);
    addRow(branchCmd(opCall, 300), 300, 1, 0, 0, 0);
    addRow(adv, 301, 1, 0, 0, 0);
    addRow(ret, 202, 1, 0, 0, 0);                     // Inner call returns first
    addRow(ret, 101, 1, 0, 0, 1);
    addRow(adv, 102, 1, 0, 0, 1);
    addRow(loopCmd(3, 105), 103, 1, 0, 0, 0);         // Body is 103 to 105
    for (int pass = 1; pass <= 3; pass++) begin
      addRow(adv, 104, 1, 0, 0, 0);
      addRow(adv, 105, 1, 0, 0, 0);
      addRow(adv, (pass < 3) ? 103 : 106, 1, 0, 0, (pass < 3) ? 0 : 1);
    end
    addRow(branchCmd(opCall, 400), 400, 1, 0, 0, 0);
    addRow(loopCmd(2, 402), 401, 1, 0, 0, 0);
    addRow(adv, 402, 1, 0, 0, 0);
    addRow(adv, 401, 1, 0, 0, 0);
    addRow(adv, 402, 1, 0, 0, 0);
    addRow(adv, 403, 1, 0, 0, 0);
    addRow(ret, 107, 1, 0, 0, 1);
    addRow(adv, 108, 1, 0, 0, 1);
    addRow(ret, 0, 0, 1, 0, 1);                       // The stale top address is not checked
    addRow(branchCmd(opJump, 500), 500, 1, 1, 0, 1);
    for (int n = 0; n < 5; n++) begin
      addRow(loopCmd(2, 600 + 10 * n), 501 + n, 1, 1, (n == 4) ? 1 : 0, 0, (n >= 3) ? 1 : 0);
    end
    addRow(adv, 506, 1, 1, 1, 0, 1);
  endtask

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  task automatic sendCommand(input seqCmd_u cmd);
    cmdWord  = cmd;
    cmdValid = 1'b1;
    @(negedge PCSCLK);
    while (!cmdReady) begin
      @(negedge PCSCLK);
    end
    @(posedge PCSCLK);  // Accepted at this edge
    #1;
    cmdValid = 1'b0;
  endtask

  task automatic takeFetch(input int row);
    @(negedge PCSCLK);
    while (!(fetchValid && fetchReady)) begin
      @(negedge PCSCLK);
    end
    if (addrKnownTab[row]) begin
      checkAddr($sformatf("fetchAddr (row %0d)", row), fetchAddr, addrTab[row]);
    end
    checkFlag($sformatf("pcError (row %0d)", row), pcError, pcErrTab[row]);
    checkFlag($sformatf("loopError (row %0d)", row), loopError, loopErrTab[row]);
    checkFlag($sformatf("pcEmpty (row %0d)", row), pcEmpty, emptyTab[row]);
    checkFlag($sformatf("pcFull (row %0d)", row), pcFull, fullTab[row]);
    @(posedge PCSCLK);
    #1;
  endtask

  initial begin
    PCSCLK     = 1'b0;
    T_RST      = 1'b1;
    cmdValid   = 1'b0;
    cmdWord    = '0;
    fetchReady = 1'b0;
    cycleCount = 0;
    void'($urandom(92));
    buildTable();
    cycleLimit = cmdTab.size() * 8 + 50;
    repeat (10) @(posedge PCSCLK);
    #1;
    T_RST = 1'b0;
    checkFlag("fetchValid after reset", fetchValid, 1'b0);
    checkFlag("pcEmpty after reset", pcEmpty, 1'b1);
    checkFlag("pcFull after reset", pcFull, 1'b0);
    checkFlag("pcError after reset", pcError, 1'b0);
    checkFlag("loopError after reset", loopError, 1'b0);
    for (int i = 0; i < cmdTab.size(); i++) begin
      sendCommand(cmdTab[i]);
      takeFetch(i);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== pcSeq.f ====
common/seqPkg.sv
pcStack/pcStack.sv
rtl/loopStack.sv
rtl/pcSequencer.sv
rtl/seqTop.sv
bench/seqTop_assert.sv
bench/seqTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = seqTb
FILELIST  = pcSeq.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the simulation prints the pass message
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
